// ==== hw/can_frame_pkg.sv ====
`default_nettype none

package can_frame_pkg;

	// ====================
	// Field widths

	typedef logic [10:0] id_a_t;   // Base identifier
	typedef logic [17:0] id_b_t;   // Identifier extension
	typedef logic [3:0]  dlc_t;    // Data length code
	typedef logic [63:0] data_t;   // First received bit ends up highest
	typedef logic [14:0] crc_t;    // CRC-15 value

	// ====================
	// Decoded frame

	// Fields in bus order
	typedef struct packed
	{
		id_a_t id_a;   // Base identifier
		logic  srr;    // Substitute remote request, extended only
		logic  ide;    // 1 for extended frames
		logic  rtr;    // Remote request
		id_b_t id_b;   // Zero in base frames
		logic  r1;     // Reserved bit, extended only
		logic  r0;     // Reserved bit
		dlc_t  dlc;    // Already clamped to 8
		data_t data;   // Right-aligned
	} can_frame_t;

endpackage

`default_nettype wire

// ==== hw/can_decode_pkg.sv ====
`default_nettype none

package can_decode_pkg;

	// ====================
	// Protocol constants

	localparam int len_id_a         = 11;
	localparam int len_id_b         = 18;
	localparam int len_dlc          = 4;
	localparam int len_crc          = 15;
	localparam int len_eof          = 7;
	localparam int len_intermission = 2;   // Third bit may already be the next SOF
	localparam int max_data_bytes   = 8;

	// x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
	localparam can_frame_pkg::crc_t crc_poly = 15'h4599;

	localparam int stuff_run = 5;   // Equal bits before a stuff bit

	// ====================
	// Decoder state

	// Order matters, ranges are used for the stuffed and CRC regions
	typedef enum logic [4:0]
	{
		state_idle,
		state_id_a,
		state_rtr_srr,
		state_ide,
		state_id_b,
		state_rtr,
		state_reserved1,
		state_reserved0,
		state_dlc,
		state_data,
		state_crc,
		state_crc_delimiter,
		state_ack_slot,
		state_ack_delimiter,
		state_eof,
		state_intermission,
		state_recovery
	} decode_state_t;

	typedef enum logic [2:0]
	{
		error_none,
		error_stuff,
		error_crc_mismatch,
		error_crc_delimiter,
		error_ack,
		error_ack_delimiter,
		error_eof_form,
		error_intermission_form
	} error_cause_t;

	// One sampled bit after destuffing
	typedef struct packed
	{
		logic strobe;        // Sample point
		logic level;         // 1 is recessive
		logic stuff;         // Drop this bit
		logic stuff_error;   // Sixth equal bit
	} rx_bit_t;

endpackage

`default_nettype wire

// ==== hw/can_bit_destuffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module can_bit_destuffer
(
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    rx,
	input  logic                    sample_point,
	input  logic                    stuff_region,
	output can_decode_pkg::rx_bit_t bit_out
);
	import can_decode_pkg::*;

	logic [stuff_run-1:0] history;   // Last sampled levels, newest in bit 0
	logic                 run;       // All history bits equal
	logic                 check;     // Bit is subject to stuffing rules

	// ====================
	// Bit history

	// Every sampled bit goes in, stuff bits too, since they start the next run
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			history <= 5'b10101;   // No run out of reset
		else if (sample_point)
			history <= {history[stuff_run-2:0], rx};
	end

	assign run   = (history == '0) || (history == '1);
	assign check = sample_point && stuff_region && run;

	// ====================
	// Marking

	always_comb
	begin
		bit_out.strobe      = sample_point;
		bit_out.level       = rx;
		bit_out.stuff       = check && (rx != history[0]);   // Opposite level after a run
		bit_out.stuff_error = check && (rx == history[0]);   // Run grew to six
	end

	// A bit is either dropped or faulty, never both
	stuff_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(bit_out.stuff && bit_out.stuff_error));

endmodule

`default_nettype wire

// ==== hw/can_crc15.sv ====
`timescale 1ns/100ps
`default_nettype none

module can_crc15
(
	input  logic                clock,
	input  logic                reset,
	input  logic                crc_init,
	input  logic                crc_shift,
	input  logic                data_bit,
	output can_frame_pkg::crc_t crc_value
);
	import can_decode_pkg::*;

	logic feedback;   // Top bit out xor new bit in

	assign feedback = crc_value[14] ^ data_bit;

	// Serial LFSR, one step per destuffed bit
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_value <= '0;
		else if (crc_init)
			crc_value <= '0;   // Start of frame
		else if (crc_shift)
			crc_value <= {crc_value[13:0], 1'b0} ^ (feedback ? crc_poly : '0);
	end

	// Init comes from the SOF bit, shifts only from id_a on
	init_shift_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(crc_init && crc_shift));

endmodule

`default_nettype wire

// ==== hw/can_frame_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module can_frame_fsm
#(
	parameter int recovery_bits = 11
)
(
	input  logic                         clock,
	input  logic                         reset,
	input  can_decode_pkg::rx_bit_t      bit_in,
	input  can_frame_pkg::crc_t          crc_value,
	output logic                         stuff_region,
	output logic                         crc_init,
	output logic                         crc_shift,
	output can_frame_pkg::can_frame_t    frame,
	output logic                         frame_valid,
	output logic                         error_valid,
	output can_decode_pkg::error_cause_t error_cause
);
	import can_frame_pkg::*;
	import can_decode_pkg::*;

	typedef logic [6:0] bit_count_t;   // Holds 64 for the longest data field

	decode_state_t state;
	decode_state_t state_next;
	bit_count_t    count;         // Shared bit counter of the current field
	bit_count_t    count_next;
	logic          take;          // Strobe of a content bit
	logic          fail;          // A check failed on this bit
	logic          done;          // Last EOF bit was clean
	error_cause_t  cause;
	can_frame_t    work;          // Frame being assembled
	crc_t          crc_rx;        // CRC as received
	logic          rtr_srr;       // RTR or SRR, known only after IDE
	dlc_t          dlc_shift;     // DLC with the current bit shifted in
	dlc_t          dlc_clamped;

	assign take = bit_in.strobe && !bit_in.stuff && !bit_in.stuff_error;

	assign dlc_shift   = {work.dlc[len_dlc-2:0], bit_in.level};
	assign dlc_clamped = dlc_shift[len_dlc-1] ? dlc_t'(max_data_bytes) : dlc_shift;

	// ====================
	// Region controls

	assign stuff_region = state inside {[state_id_a:state_crc_delimiter]};
	assign crc_init     = bit_in.strobe && (state == state_idle) && !bit_in.level;   // SOF
	assign crc_shift    = take && (state inside {[state_id_a:state_data]});

	// ====================
	// Next state and checks

	always_comb
	begin
		state_next = state;
		count_next = count;
		fail       = 1'b0;
		done       = 1'b0;
		cause      = error_none;

		if (bit_in.stuff_error)
		begin
			fail  = 1'b1;
			cause = error_stuff;
		end
		else if (take)
		begin
			unique case (state)
				state_idle:
					if (!bit_in.level)
						state_next = state_id_a;   // Dominant SOF
				state_id_a:
				begin
					count_next = count + 1'b1;
					if (count == bit_count_t'(len_id_a - 1))
					begin
						state_next = state_rtr_srr;
						count_next = '0;
					end
				end
				state_rtr_srr:
					state_next = state_ide;
				state_ide:
					state_next = bit_in.level ? state_id_b : state_reserved0;
				state_id_b:
				begin
					count_next = count + 1'b1;
					if (count == bit_count_t'(len_id_b - 1))
					begin
						state_next = state_rtr;
						count_next = '0;
					end
				end
				state_rtr:
					state_next = state_reserved1;
				state_reserved1:
					state_next = state_reserved0;
				state_reserved0:
					state_next = state_dlc;
				state_dlc:
				begin
					count_next = count + 1'b1;
					if (count == bit_count_t'(len_dlc - 1))
					begin
						count_next = '0;
						// Remote frames and empty frames go straight to CRC
						state_next = (work.rtr || (dlc_clamped == '0)) ? state_crc : state_data;
					end
				end
				state_data:
				begin
					count_next = count + 1'b1;
					if (count == bit_count_t'({work.dlc, 3'b000}) - 1'b1)
					begin
						state_next = state_crc;
						count_next = '0;
					end
				end
				state_crc:
				begin
					count_next = count + 1'b1;
					if (count == bit_count_t'(len_crc - 1))
					begin
						state_next = state_crc_delimiter;
						count_next = '0;
					end
				end
				state_crc_delimiter:
				begin
					state_next = state_ack_slot;
					if (!bit_in.level)
					begin
						fail  = 1'b1;
						cause = error_crc_delimiter;
					end
				end
				state_ack_slot:
				begin
					state_next = state_ack_delimiter;
					if (bit_in.level)   // Nobody acknowledged
					begin
						fail  = 1'b1;
						cause = error_ack;
					end
				end
				state_ack_delimiter:
				begin
					state_next = state_eof;
					if (crc_value != crc_rx)   // CRC error is flagged here
					begin
						fail  = 1'b1;
						cause = error_crc_mismatch;
					end
					else if (!bit_in.level)
					begin
						fail  = 1'b1;
						cause = error_ack_delimiter;
					end
				end
				state_eof:
				begin
					count_next = count + 1'b1;
					if (!bit_in.level)
					begin
						fail  = 1'b1;
						cause = error_eof_form;
					end
					else if (count == bit_count_t'(len_eof - 1))
					begin
						done       = 1'b1;
						state_next = state_intermission;
						count_next = '0;
					end
				end
				state_intermission:
				begin
					count_next = count + 1'b1;
					if (!bit_in.level)   // No overload frames here
					begin
						fail  = 1'b1;
						cause = error_intermission_form;
					end
					else if (count == bit_count_t'(len_intermission - 1))
					begin
						state_next = state_idle;
						count_next = '0;
					end
				end
				state_recovery:
				begin
					count_next = count + 1'b1;
					if (!bit_in.level)
						count_next = '0;   // Start the recessive run again
					else if (count == bit_count_t'(recovery_bits - 1))
					begin
						state_next = state_idle;
						count_next = '0;
					end
				end
				default:
					state_next = state_idle;
			endcase
		end

		// Any failure waits for bus integration
		if (fail)
		begin
			state_next = state_recovery;
			count_next = '0;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state       <= state_idle;
			count       <= '0;
			frame_valid <= 1'b0;
			error_valid <= 1'b0;
			error_cause <= error_none;
		end
		else
		begin
			state       <= state_next;
			count       <= count_next;
			frame_valid <= done;
			error_valid <= fail;
			error_cause <= cause;
		end
	end

	// ====================
	// Field capture

	always_ff @(posedge clock)
	begin
		if (take)
		begin
			case (state)
				state_idle:
					work <= '0;   // Unused data bytes stay zero
				state_id_a:
					work.id_a <= {work.id_a[len_id_a-2:0], bit_in.level};
				state_rtr_srr:
					rtr_srr <= bit_in.level;
				state_ide:
				begin
					work.ide <= bit_in.level;
					if (bit_in.level)
						work.srr <= rtr_srr;   // Extended frame
					else
						work.rtr <= rtr_srr;   // Base frame
				end
				state_id_b:
					work.id_b <= {work.id_b[len_id_b-2:0], bit_in.level};
				state_rtr:
					work.rtr <= bit_in.level;
				state_reserved1:
					work.r1 <= bit_in.level;
				state_reserved0:
					work.r0 <= bit_in.level;
				state_dlc:
					work.dlc <= (count == bit_count_t'(len_dlc - 1)) ? dlc_clamped : dlc_shift;
				state_data:
					work.data <= {work.data[$bits(data_t)-2:0], bit_in.level};
				state_crc:
					crc_rx <= {crc_rx[len_crc-2:0], bit_in.level};
				default:
					;
			endcase
		end

		if (done)
			frame <= work;
	end

	// ====================
	// Assertions

	valid_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(frame_valid && error_valid));

	count_range: assert property (@(posedge clock) disable iff (reset)
		count < 7'd64);

endmodule

`default_nettype wire

// ==== hw/can_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module can_decoder
#(
	parameter int recovery_bits = 11   // Recessive bits before idle after an error
)
(
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         rx,             // 1 is recessive
	input  logic                         sample_point,   // One clock per bit time
	output can_frame_pkg::can_frame_t    frame,
	output logic                         frame_valid,
	output logic                         error_valid,
	output can_decode_pkg::error_cause_t error_cause
);
	import can_frame_pkg::*;
	import can_decode_pkg::*;

	rx_bit_t rx_bit;         // Sampled bit with stuff marks
	logic    stuff_region;
	logic    crc_init;
	logic    crc_shift;
	crc_t    crc_value;

	can_bit_destuffer i_destuffer
	(
		.clock        (clock),
		.reset        (reset),
		.rx           (rx),
		.sample_point (sample_point),
		.stuff_region (stuff_region),
		.bit_out      (rx_bit)
	);

	can_crc15 i_crc
	(
		.clock     (clock),
		.reset     (reset),
		.crc_init  (crc_init),
		.crc_shift (crc_shift),
		.data_bit  (rx_bit.level),
		.crc_value (crc_value)
	);

	can_frame_fsm
	#(
		.recovery_bits (recovery_bits)
	)
	i_fsm
	(
		.clock        (clock),
		.reset        (reset),
		.bit_in       (rx_bit),
		.crc_value    (crc_value),
		.stuff_region (stuff_region),
		.crc_init     (crc_init),
		.crc_shift    (crc_shift),
		.frame        (frame),
		.frame_valid  (frame_valid),
		.error_valid  (error_valid),
		.error_cause  (error_cause)
	);

endmodule

`default_nettype wire

// ==== include/can_tb_model.svh ====
`ifndef CAN_TB_MODEL_SVH
`define CAN_TB_MODEL_SVH

// ====================
// Random source

logic [31:0] lfsr_state = 32'h13dd_a402;

// Fibonacci form, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_step();
	logic feedback;
	feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], feedback};
	return feedback;
endfunction

// One step per bit taken, first bit ends up highest
function automatic logic [63:0] random_bits(input int count);
	logic [63:0] value;
	value = '0;
	for (int i = 0; i < count; i++)
		value = {value[62:0], lfsr_step()};
	return value;
endfunction

// ====================
// Frame builder

localparam int fault_none  = 0;
localparam int fault_crc   = 1;   // One CRC bit flipped
localparam int fault_stuff = 2;   // First stuff bit left out
localparam int fault_ack   = 3;   // Nobody drives the ACK slot
localparam int fault_eof   = 4;   // One dominant EOF bit

logic raw_bits[$];   // SOF through CRC, unstuffed
logic bus_bits[$];   // As driven on the bus

function automatic void push_field(input logic [63:0] value, input int width);
	for (int i = width - 1; i >= 0; i--)
		raw_bits.push_back(value[i]);   // MSB first
endfunction

// Serial CRC-15 over everything collected so far
function automatic logic [14:0] crc15_of_raw();
	logic [14:0] crc;
	logic        top;
	crc = '0;
	foreach (raw_bits[i])
	begin
		top = crc[14] ^ raw_bits[i];
		crc = {crc[13:0], 1'b0};
		if (top)
			crc = crc ^ 15'h4599;   // x^15+x^14+x^10+x^8+x^7+x^4+x^3+1
	end
	return crc;
endfunction

function automatic void build_frame(input can_frame_t tx, input int fault);
	logic [14:0] crc;
	int          bytes;
	int          run;
	int          flip;
	int          eof_dominant;
	logic        dropped;
	raw_bits.delete();
	bus_bits.delete();
	push_field(64'd0, 1);   // SOF
	push_field(tx.id_a, 11);
	if (tx.ide)
	begin
		push_field(tx.srr, 1);
		push_field(64'd1, 1);   // IDE
		push_field(tx.id_b, 18);
		push_field(tx.rtr, 1);
		push_field(tx.r1, 1);
	end
	else
	begin
		push_field(tx.rtr, 1);
		push_field(64'd0, 1);   // IDE
	end
	push_field(tx.r0, 1);
	push_field(tx.dlc, 4);   // Raw code, may exceed 8
	bytes = tx.rtr ? 0 : ((tx.dlc > 4'd8) ? 8 : int'(tx.dlc));
	push_field(tx.data, bytes * 8);   // Low bytes only
	crc = crc15_of_raw();
	if (fault == fault_crc)
	begin
		flip      = int'(random_bits(4) % 15);
		crc[flip] = ~crc[flip];
	end
	push_field(crc, 15);

	// Stuffing from SOF to the last CRC bit
	run     = 0;
	dropped = 1'b0;
	foreach (raw_bits[i])
	begin
		if (i > 0 && raw_bits[i] == bus_bits[bus_bits.size() - 1])
			run++;
		else
			run = 1;
		bus_bits.push_back(raw_bits[i]);
		if (run == 5)
		begin
			if (fault == fault_stuff && !dropped)
				dropped = 1'b1;   // Sixth equal bit follows
			else
			begin
				bus_bits.push_back(!raw_bits[i]);
				run = 1;
			end
		end
	end

	bus_bits.push_back(1'b1);   // CRC delimiter
	bus_bits.push_back(fault == fault_ack);   // ACK slot
	bus_bits.push_back(1'b1);   // ACK delimiter
	eof_dominant = (fault == fault_eof) ? int'(random_bits(3) % 7) : -1;
	for (int i = 0; i < 7; i++)
		bus_bits.push_back(i != eof_dominant);
endfunction

// ====================
// Reference frame

function automatic can_frame_t expected_frame(input can_frame_t tx);
	can_frame_t result;
	int         bytes;
	result     = tx;
	result.dlc = (tx.dlc > 4'd8) ? 4'd8 : tx.dlc;
	bytes      = tx.rtr ? 0 : int'(result.dlc);
	result.data = '0;
	for (int i = 0; i < bytes * 8; i++)
		result.data[i] = tx.data[i];   // Right-aligned, rest zero
	if (!tx.ide)
	begin
		result.srr  = 1'b0;
		result.id_b = '0;
		result.r1   = 1'b0;
	end
	return result;
endfunction

`endif

// ==== testbench/can_decoder_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module can_decoder_tb;
	import can_frame_pkg::*;
	import can_decode_pkg::*;

	localparam int recovery_bits  = 11;
	localparam int timeout_clocks = 2000;
	localparam int idle_bits      = recovery_bits + 3;   // Gap between frames

	logic         clock;
	logic         reset;
	logic         rx;
	logic         sample_point;
	can_frame_t   frame;
	logic         frame_valid;
	logic         error_valid;
	error_cause_t error_cause;

	int           frames_seen   = 0;   // Pulse counters from the monitor
	int           errors_seen   = 0;
	can_frame_t   frame_seen;
	error_cause_t cause_seen;
	int           checks_failed = 0;
	int           tests_run     = 0;
	int           tests_failed  = 0;

	`include "can_tb_model.svh"

	can_decoder
	#(
		.recovery_bits (recovery_bits)
	)
	i_dut
	(
		.clock        (clock),
		.reset        (reset),
		.rx           (rx),
		.sample_point (sample_point),
		.frame        (frame),
		.frame_valid  (frame_valid),
		.error_valid  (error_valid),
		.error_cause  (error_cause)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#10 clock = ~clock;   // 20 ns period
	end

	// ====================
	// Output monitor

	// Registered outputs are read on the falling edge
	always @(negedge clock)
	begin
		if (frame_valid)
		begin
			frames_seen++;
			frame_seen = frame;
		end
		if (error_valid)
		begin
			errors_seen++;
			cause_seen = error_cause;
		end
	end

	task automatic compare(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			checks_failed++;
		end
	endtask

	// ====================
	// Bus driver

	// Four clocks per bit with the strobe in the last one
	task automatic send_bit(input logic level);
		@(posedge clock);
		#2;
		rx = level;
		repeat (2)
			@(posedge clock);
		#2;
		sample_point = 1'b1;   // Taken on the next edge
		@(posedge clock);
		#2;
		sample_point = 1'b0;
	endtask

	task automatic send_bits();
		foreach (bus_bits[i])
			send_bit(bus_bits[i]);
	endtask

	task automatic send_idle(input int count);
		repeat (count)
			send_bit(1'b1);   // Recessive
	endtask

	task automatic wait_pulse(input string name, input int start);
		int clocks;
		clocks = 0;
		while ((frames_seen + errors_seen == start) && clocks < timeout_clocks)
		begin
			@(posedge clock);
			clocks++;
		end
		if (clocks >= timeout_clocks)
		begin
			$display("Timeout in %s: no frame or error pulse within %0d clocks",
				name, timeout_clocks);
			checks_failed++;
		end
	endtask

	// ====================
	// Tests

	function automatic can_frame_t random_frame(input logic ide);
		can_frame_t f;
		f      = '0;
		f.id_a = id_a_t'(random_bits(11));
		f.ide  = ide;
		if (ide)
		begin
			f.srr  = lfsr_step();
			f.id_b = id_b_t'(random_bits(18));
			f.r1   = lfsr_step();
		end
		f.r0   = lfsr_step();
		f.dlc  = dlc_t'(random_bits(4) % 9);   // 0 to 8
		f.data = random_bits(64);
		return f;
	endfunction

	task automatic run_test(input string name, input can_frame_t tx, input int fault,
		input error_cause_t cause);
		int         failed_before;
		int         frames_before;
		int         errors_before;
		can_frame_t expected;
		failed_before = checks_failed;
		frames_before = frames_seen;
		errors_before = errors_seen;
		expected      = expected_frame(tx);
		build_frame(tx, fault);
		fork
			send_bits();
			wait_pulse(name, frames_before + errors_before);
		join
		send_idle(idle_bits);   // Also lets recovery finish
		if (fault == fault_none)
		begin
			compare({name, " frame_valid pulses"}, 1, frames_seen - frames_before);
			compare({name, " error_valid pulses"}, 0, errors_seen - errors_before);
			compare({name, " frame"}, expected, frame_seen);
		end
		else
		begin
			compare({name, " frame_valid pulses"}, 0, frames_seen - frames_before);
			compare({name, " error_valid pulses"}, 1, errors_seen - errors_before);
			compare({name, " error_cause"}, cause, cause_seen);
		end
		tests_run++;
		if (checks_failed == failed_before)
			$display("PASS %s", name);
		else
		begin
			tests_failed++;
			$display("FAIL %s", name);
		end
	endtask

	initial
	begin
		can_frame_t tx;
		rx           = 1'b1;
		sample_point = 1'b0;
		reset        = 1'b1;
		repeat (5)
			@(posedge clock);
		#2;
		reset = 1'b0;
		send_idle(idle_bits);

		for (int i = 0; i < 4; i++)
			run_test($sformatf("base_%0d", i), random_frame(1'b0), fault_none, error_none);
		for (int i = 0; i < 4; i++)
			run_test($sformatf("extended_%0d", i), random_frame(1'b1), fault_none, error_none);
		for (int i = 0; i < 3; i++)
		begin
			tx     = random_frame(i[0]);
			tx.dlc = dlc_t'(9 + random_bits(3) % 7);   // 9 to 15
			run_test($sformatf("long_dlc_%0d", i), tx, fault_none, error_none);
		end
		for (int i = 0; i < 2; i++)
		begin
			tx     = random_frame(i[0]);
			tx.rtr = 1'b1;   // Data field must be absent
			run_test($sformatf("remote_%0d", i), tx, fault_none, error_none);
		end

		for (int i = 0; i < 2; i++)
			run_test($sformatf("crc_flip_%0d", i), random_frame(i[0]), fault_crc,
				error_crc_mismatch);
		tx            = random_frame(1'b0);
		tx.id_a[10:6] = '0;   // SOF plus five zeros
		run_test("stuff_violation", tx, fault_stuff, error_stuff);

		// Late faults each followed by a clean frame
		run_test("recessive_ack", random_frame(1'b0), fault_ack, error_ack);
		run_test("after_ack_error", random_frame(1'b1), fault_none, error_none);
		run_test("dominant_eof", random_frame(1'b1), fault_eof, error_eof_form);
		run_test("after_eof_error", random_frame(1'b0), fault_none, error_none);

		$display("Tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, checks_failed);
		if (checks_failed == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
hw/can_frame_pkg.sv
hw/can_decode_pkg.sv
hw/can_bit_destuffer.sv
hw/can_crc15.sv
hw/can_frame_fsm.sv
hw/can_decoder.sv
testbench/can_decoder_tb.sv

// ==== Bender.yml ====
package:
  name: can_decoder

sources:
  # Packages first, then leaf modules, then the top level
  - hw/can_frame_pkg.sv
  - hw/can_decode_pkg.sv
  - hw/can_bit_destuffer.sv
  - hw/can_crc15.sv
  - hw/can_frame_fsm.sv
  - hw/can_decoder.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/can_decoder_tb.sv
